// ==== filelist.f ====
logic/apv_pkg.sv
logic/zero_suppressor.sv
logic/event_fifo.sv
logic/event_counter.sv
logic/channel_processor.sv
testbench/channel_properties.sv
testbench/channel_checker.sv
testbench/tb_channel_processor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_channel_processor
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation stopped early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_channel_processor.sv ====
// Testbench top for the readout channel: random frames, FIFO reads, clear and overflow runs
module tb_channel_processor import apv_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RANDOM = 12;
	localparam int N_SATURATE = EVCNT_MAX + 2;
	localparam int N_CLEAR = 3;
	// Enough all-hit frames to run past the FIFO depth
	localparam int N_BURST = FIFO_DEPTH / (STRIPS_PER_FRAME + 4) + 2;
	localparam int N_EVENTS = N_RANDOM + N_SATURATE + N_CLEAR + N_BURST;
	localparam int FRAME_CYCLES = 2 * (STRIPS_PER_FRAME + 2);
	localparam int GAP_CYCLES = 6;
	localparam int DRAIN_CYCLES = 2 * (STRIPS_PER_FRAME + 4);
	localparam int CYCLE_LIMIT = N_EVENTS * (FRAME_CYCLES + GAP_CYCLES + DRAIN_CYCLES)
		+ 8 * STRIPS_PER_FRAME + 1000;

	logic CLK;
	logic RSTb;
	logic all_clear;
	logic frame_strobe;
	logic [FRAME_W-1:0] frame_data;
	logic [SAMPLE_W-1:0] mean;
	logic base_sub_en;
	logic [CH_ID_W-1:0] ch_id;
	logic [MODULE_ID_W-1:0] module_id;
	logic thr_we;
	logic [STRIP_ADDR_W-1:0] thr_addr;
	logic [SAMPLE_W-1:0] thr_data;
	logic fifo_rd;
	logic event_read;
	logic [WORD_W-1:0] data_out;
	logic fifo_empty;
	logic fifo_full;
	logic [FIFO_COUNT_W-1:0] used_words;
	logic overflow;
	logic event_present;
	logic check_req;
	int test_id;
	int data_errors;
	int flag_errors;
	logic read_en;
	logic [15:0] lfsr;
	int cycle_count = 0;

	channel_processor u_dut (.*);

	channel_checker u_chk (.*);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [SAMPLE_W-1:0] random_threshold();
		logic [1:0] sel;
		sel = 2'(rand_bits(2));
		case (sel)
			2'd0:    return THR_DISABLED;
			2'd1:    return SAMPLE_W'(rand_bits(5));
			default: return SAMPLE_W'(rand_bits(SAMPLE_W));
		endcase
	endfunction

	// One clock step; strobes drop back and the reader decides on this cycle's read
	task automatic tick();
		@(posedge CLK);
		#1;
		frame_strobe = 1'b0;
		thr_we = 1'b0;
		all_clear = 1'b0;
		check_req = 1'b0;
		event_read = 1'b0;
		if (fifo_rd && (data_out[WORD_W-1 -: 2] == WT_EVT_TRAILER))
			event_read = 1'b1;
		fifo_rd = 1'b0;
		if (read_en && !fifo_empty && (rand_bits(2) != 0))
			fifo_rd = 1'b1;
	endtask

	task automatic write_thresholds(input int mode);
		for (int i = 0; i < STRIPS_PER_FRAME; i++)
		begin
			tick();
			thr_we = 1'b1;
			thr_addr = STRIP_ADDR_W'(i);
			case (mode)
				1:       thr_data = THR_DISABLED;
				2:       thr_data = '0;
				default: thr_data = random_threshold();
			endcase
		end
		tick();
	endtask

	task automatic send_frame();
		tick();
		mean = SAMPLE_W'(rand_bits(SAMPLE_W));
		base_sub_en = rand_bits(1) != 0;
		ch_id = CH_ID_W'(rand_bits(CH_ID_W));
		module_id = MODULE_ID_W'(rand_bits(MODULE_ID_W));
		frame_strobe = 1'b1;
		frame_data = FRAME_W'(rand_bits(FRAME_W));
		for (int s = 0; s < STRIPS_PER_FRAME; s++)
		begin
			tick();
			while (rand_bits(2) == 0)
				tick();
			frame_strobe = 1'b1;
			// Half the samples land close to the mean, some of them below it
			if (rand_bits(1) != 0)
				frame_data = FRAME_W'(rand_bits(FRAME_W));
			else
				frame_data = FRAME_W'({1'b0, mean}) + FRAME_W'(rand_bits(6)) - FRAME_W'(32);
		end
		tick();
		frame_strobe = 1'b1;
		frame_data = FRAME_W'(rand_bits(FRAME_W));
		repeat (2 + int'(rand_bits(2)))
			tick();
	endtask

	task automatic drain();
		read_en = 1'b1;
		repeat (4)
			tick();
		while (!fifo_empty || fifo_rd)
			tick();
		repeat (3)
			tick();
	endtask

	task automatic request_check();
		tick();
		check_req = 1'b1;
		tick();
	endtask

	task automatic pulse_clear();
		tick();
		all_clear = 1'b1;
		tick();
	endtask

	initial
	begin
		lfsr = 16'd49;
		RSTb = 1'b0;
		all_clear = 1'b0;
		frame_strobe = 1'b0;
		frame_data = '0;
		mean = '0;
		base_sub_en = 1'b0;
		ch_id = '0;
		module_id = '0;
		thr_we = 1'b0;
		thr_addr = '0;
		thr_data = '0;
		fifo_rd = 1'b0;
		event_read = 1'b0;
		check_req = 1'b0;
		read_en = 1'b0;
		test_id = 0;
		repeat (3)
			@(posedge CLK);
		#1;
		RSTb = 1'b1;
		request_check();

		// Mixed thresholds and baselines, reads running alongside the frames
		test_id = 1;
		write_thresholds(0);
		read_en = 1'b1;
		repeat (N_RANDOM)
			send_frame();
		drain();
		request_check();

		// Headers and trailers only; the event count saturates before any read
		test_id = 2;
		write_thresholds(1);
		read_en = 1'b0;
		repeat (N_SATURATE)
			send_frame();
		drain();
		request_check();

		test_id = 3;
		write_thresholds(0);
		read_en = 1'b0;
		repeat (N_CLEAR)
			send_frame();
		repeat (4)
			tick();
		pulse_clear();
		request_check();

		// Every strip hits, nothing read until the FIFO has overflowed
		test_id = 4;
		write_thresholds(2);
		read_en = 1'b0;
		repeat (N_BURST)
			send_frame();
		repeat (4)
			tick();
		// FIFO sits full with overflow set before the first read
		request_check();
		drain();
		request_check();
		pulse_clear();
		request_check();

		$display("Error count: %0d data, %0d flag", data_errors, flag_errors);
		if ((data_errors + flag_errors) == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== testbench/channel_checker.sv ====
// Reference model of the readout channel; predicts FIFO words, flags and event count and compares
module channel_checker import apv_pkg::*;
(
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    all_clear,
	input  logic                    frame_strobe,
	input  logic [FRAME_W-1:0]      frame_data,
	input  logic [SAMPLE_W-1:0]     mean,
	input  logic                    base_sub_en,
	input  logic [CH_ID_W-1:0]      ch_id,
	input  logic [MODULE_ID_W-1:0]  module_id,
	input  logic                    thr_we,
	input  logic [STRIP_ADDR_W-1:0] thr_addr,
	input  logic [SAMPLE_W-1:0]     thr_data,
	input  logic                    fifo_rd,
	input  logic                    event_read,
	input  logic [WORD_W-1:0]       data_out,
	input  logic                    fifo_empty,
	input  logic                    fifo_full,
	input  logic [FIFO_COUNT_W-1:0] used_words,
	input  logic                    overflow,
	input  logic                    event_present,
	input  logic                    check_req,
	input  int                      test_id,
	output int                      data_errors,
	output int                      flag_errors
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [SAMPLE_W-1:0] thr_model [STRIPS_PER_FRAME];
	logic [WORD_W-1:0] expected_q [$];
	logic [WORD_W-1:0] pending_word;
	logic pending = 1'b0;
	int frame_pos = 0;
	int hit_count = 0;
	int event_cnt = 0;
	logic present_model = 1'b0;
	logic overflow_model = 1'b0;
	// Trailer strobes on their way to the event counter
	logic [2:0] done_delay = '0;
	logic trailer_seen;
	int n_data = 0;
	int n_flag = 0;

	assign data_errors = n_data;
	assign flag_errors = n_flag;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset";
			1:       return "random_frames";
			2:       return "event_count";
			3:       return "all_clear";
			default: return "overflow";
		endcase
	endfunction

	function automatic void flag_mismatch(input string what, input int exp, input int act);
		$display("[ERROR] %s %s: expected %0h, actual %0h", test_name(test_id), what, exp, act);
		n_flag++;
	endfunction

	// Occupancy is the queue length, so a word pushed onto a full queue is one the FIFO drops
	function automatic void push_word(input logic [WORD_W-1:0] w);
		if (expected_q.size() >= FIFO_DEPTH)
			overflow_model = 1'b1;
		else
			expected_q.push_back(w);
	endfunction

	function automatic void handle_strobe();
		logic [SAMPLE_W-1:0] base;
		logic [FRAME_W-1:0] diff;
		logic [SAMPLE_W-1:0] thr;
		logic [STRIP_ADDR_W-1:0] strip;
		if (frame_pos == 0)
		begin
			push_word({WT_HEADER, 1'b0, mean[SAMPLE_W-1], frame_data, ch_id});
			hit_count = 0;
			frame_pos = 1;
		end
		else if (frame_pos <= STRIPS_PER_FRAME)
		begin
			strip = STRIP_ADDR_W'(frame_pos - 1);
			base = base_sub_en ? mean : '0;
			// Modulo 2^13, read back as unsigned
			diff = frame_data - FRAME_W'(base);
			thr = thr_model[strip];
			if ((thr != THR_DISABLED) && (diff > FRAME_W'(thr)))
			begin
				push_word({WT_HIT, strip, diff[SAMPLE_W-1:0]});
				hit_count++;
			end
			frame_pos++;
		end
		else
		begin
			push_word({WT_DEC_TRAILER, 2'b00, module_id, frame_data[SAMPLE_W-1:0]});
			push_word({WT_EVT_TRAILER, mean[SAMPLE_W-2:0], WCNT_W'(WORD_COUNT_INIT + hit_count)});
			frame_pos = 0;
		end
	endfunction

	function automatic void check_levels();
		if (fifo_empty !== (expected_q.size() == 0))
			flag_mismatch("fifo_empty", int'(expected_q.size() == 0), int'(fifo_empty));
		if (fifo_full !== (expected_q.size() == FIFO_DEPTH))
			flag_mismatch("fifo_full", int'(expected_q.size() == FIFO_DEPTH), int'(fifo_full));
		if (used_words !== FIFO_COUNT_W'(expected_q.size()))
			flag_mismatch("used_words", expected_q.size(), int'(used_words));
		if (overflow !== overflow_model)
			flag_mismatch("overflow", int'(overflow_model), int'(overflow));
	endfunction

	always @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			expected_q.delete();
			pending = 1'b0;
			frame_pos = 0;
			event_cnt = 0;
			present_model = 1'b0;
			overflow_model = 1'b0;
			done_delay = '0;
		end
		else
		begin
			// Word taken by the previous read sits on data_out now
			if (pending && (data_out !== pending_word))
			begin
				$display("[ERROR] %s: expected %h, actual %h", test_name(test_id), pending_word,
					data_out);
				n_data++;
			end
			pending = 1'b0;
			if (event_present !== present_model)
				flag_mismatch("event_present", int'(present_model), int'(event_present));
			if (check_req)
				check_levels();
			if (all_clear)
			begin
				expected_q.delete();
				frame_pos = 0;
				event_cnt = 0;
				present_model = 1'b0;
				overflow_model = 1'b0;
				done_delay = '0;
			end
			else
			begin
				if (fifo_rd && !fifo_empty)
				begin
					if (expected_q.size() == 0)
					begin
						$display("Test %s: FIFO was read while no word was expected",
							test_name(test_id));
						n_data++;
					end
					else
					begin
						pending_word = expected_q.pop_front();
						pending = 1'b1;
					end
				end
				trailer_seen = frame_strobe && (frame_pos > STRIPS_PER_FRAME);
				if (frame_strobe)
					handle_strobe();
				if (thr_we)
					thr_model[thr_addr] = thr_data;
				// Flag trails the count, increment wins over a simultaneous read
				present_model = (event_cnt != 0);
				if (done_delay[2])
				begin
					if (event_cnt < EVCNT_MAX)
						event_cnt++;
				end
				else if (event_read && (event_cnt > 0))
					event_cnt--;
				done_delay = {done_delay[1:0], trailer_seen};
			end
		end
	end

endmodule

// ==== testbench/channel_properties.sv ====
// Concurrent checks on the channel's FIFO flags and event flag, bound into the top level
module channel_properties
(
	input logic CLK,
	input logic RSTb,
	input logic all_clear,
	input logic fifo_empty,
	input logic fifo_full,
	input logic overflow,
	input logic event_present
);
	timeunit 1ns;
	timeprecision 1ps;

	// A FIFO cannot be empty and full at once
	a_empty_full_exclusive: assert property (@(posedge CLK) disable iff (!RSTb)
		!(fifo_empty && fifo_full))
		else $error("FIFO reports empty and full in the same cycle");

	// Overflow is sticky until a clear
	a_overflow_sticky: assert property (@(posedge CLK) disable iff (!RSTb)
		$fell(overflow) |-> $past(all_clear))
		else $error("Overflow flag dropped without a clear");

	a_present_low_after_reset: assert property (@(posedge CLK)
		$rose(RSTb) |-> !event_present)
		else $error("Event flag is high right after reset");

endmodule

bind channel_processor channel_properties u_props (
	.CLK           (CLK),
	.RSTb          (RSTb),
	.all_clear     (all_clear),
	.fifo_empty    (fifo_empty),
	.fifo_full     (fifo_full),
	.overflow      (overflow),
	.event_present (event_present)
);

// ==== logic/channel_processor.sv ====
// Top of one strip readout channel: zero suppression, output FIFO and event counter
module channel_processor import apv_pkg::*;
(
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    all_clear,
	input  logic                    frame_strobe,
	input  logic [FRAME_W-1:0]      frame_data,
	input  logic [SAMPLE_W-1:0]     mean,
	input  logic                    base_sub_en,
	input  logic [CH_ID_W-1:0]      ch_id,
	input  logic [MODULE_ID_W-1:0]  module_id,
	input  logic                    thr_we,
	input  logic [STRIP_ADDR_W-1:0] thr_addr,
	input  logic [SAMPLE_W-1:0]     thr_data,
	input  logic                    fifo_rd,
	input  logic                    event_read,
	output logic [WORD_W-1:0]       data_out,
	output logic                    fifo_empty,
	output logic                    fifo_full,
	output logic [FIFO_COUNT_W-1:0] used_words,
	output logic                    overflow,
	output logic                    event_present
);

	logic fifo_wr;
	logic [WORD_W-1:0] fifo_wdata;
	logic event_done;

	zero_suppressor u_zs (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.all_clear    (all_clear),
		.frame_strobe (frame_strobe),
		.frame_data   (frame_data),
		.mean         (mean),
		.base_sub_en  (base_sub_en),
		.ch_id        (ch_id),
		.module_id    (module_id),
		.thr_we       (thr_we),
		.thr_addr     (thr_addr),
		.thr_data     (thr_data),
		.fifo_wr      (fifo_wr),
		.fifo_wdata   (fifo_wdata),
		.event_done   (event_done)
	);

	event_fifo u_fifo (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.all_clear  (all_clear),
		.wr         (fifo_wr),
		.wdata      (fifo_wdata),
		.rd         (fifo_rd),
		.rdata      (data_out),
		.empty      (fifo_empty),
		.full       (fifo_full),
		.used_words (used_words),
		.overflow   (overflow)
	);

	// Counts up on each written event trailer, down on each host acknowledge
	event_counter u_evcnt (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.all_clear     (all_clear),
		.inc           (event_done),
		.dec           (event_read),
		.event_present (event_present)
	);

endmodule

// ==== logic/event_counter.sv ====
// Saturating tally of complete events waiting in the output buffer, with a registered present flag
module event_counter import apv_pkg::*;
(
	input  logic CLK,
	input  logic RSTb,
	input  logic all_clear,
	input  logic inc,
	input  logic dec,
	output logic event_present
);

	logic [EVCNT_W-1:0] cnt;

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			cnt <= '0;
			event_present <= 1'b0;
		end
		else if (all_clear)
		begin
			cnt <= '0;
			event_present <= 1'b0;
		end
		else
		begin
			// Flag trails the count by one cycle
			event_present <= (cnt != '0);
			if (inc)
			begin
				if (cnt != EVCNT_W'(EVCNT_MAX))
					cnt <= cnt + 1'b1;
			end
			else if (dec && (cnt != '0))
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// ==== logic/event_fifo.sv ====
// Single-clock output buffer for formatted event words, read word by word from outside
module event_fifo import apv_pkg::*;
(
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    all_clear,
	input  logic                    wr,
	input  logic [WORD_W-1:0]       wdata,
	input  logic                    rd,
	output logic [WORD_W-1:0]       rdata,
	output logic                    empty,
	output logic                    full,
	output logic [FIFO_COUNT_W-1:0] used_words,
	output logic                    overflow
);

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	// Count runs 0 to FIFO_DEPTH, one bit wider than the pointers
	assign full = (used_words == FIFO_COUNT_W'(FIFO_DEPTH));
	assign empty = (used_words == '0);
	assign wr_ok = wr && !full;
	assign rd_ok = rd && !empty;

	always_ff @(posedge CLK)
	begin
		if (wr_ok)
			mem[wr_ptr] <= wdata;
		if (rd_ok)
			rdata <= mem[rd_ptr];
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used_words <= '0;
			overflow <= 1'b0;
		end
		else if (all_clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used_words <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   used_words <= used_words + 1'b1;
				2'b01:   used_words <= used_words - 1'b1;
				default: used_words <= used_words;
			endcase
			// Sticky until reset or clear
			if (wr && full)
				overflow <= 1'b1;
		end
	end

endmodule

// ==== logic/zero_suppressor.sv ====
// Frame sequencer with threshold RAM, baseline subtraction and threshold cut feeding the event FIFO
module zero_suppressor import apv_pkg::*;
(
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    all_clear,
	input  logic                    frame_strobe,
	input  logic [FRAME_W-1:0]      frame_data,
	input  logic [SAMPLE_W-1:0]     mean,
	input  logic                    base_sub_en,
	input  logic [CH_ID_W-1:0]      ch_id,
	input  logic [MODULE_ID_W-1:0]  module_id,
	input  logic                    thr_we,
	input  logic [STRIP_ADDR_W-1:0] thr_addr,
	input  logic [SAMPLE_W-1:0]     thr_data,
	output logic                    fifo_wr,
	output logic [WORD_W-1:0]       fifo_wdata,
	output logic                    event_done
);

	zs_state_e state;
	logic [STRIP_ADDR_W-1:0] strip_cnt;
	logic [SAMPLE_W-1:0] thr_ram [STRIPS_PER_FRAME];
	logic [SAMPLE_W-1:0] enabled_mean;
	logic header_go;

	// First pipeline stage
	logic s1_valid;
	word_type_e s1_type;
	logic [FRAME_W-1:0] s1_data;
	logic [SAMPLE_W-1:0] s1_thr;
	logic [STRIP_ADDR_W-1:0] s1_strip;

	// Second pipeline stage
	logic hit_pass;
	logic [WCNT_W-1:0] word_count;
	logic [WORD_W-1:0] next_word;

	assign enabled_mean = base_sub_en ? mean : '0;
	assign header_go = frame_strobe && (state == ZS_IDLE);

	// Host write port of the threshold RAM
	always_ff @(posedge CLK)
	begin
		if (thr_we)
			thr_ram[thr_addr] <= thr_data;
	end

	// Strip counting classifies each strobe as header, sample or trailer
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			state <= ZS_IDLE;
			strip_cnt <= '0;
		end
		else if (all_clear)
		begin
			state <= ZS_IDLE;
			strip_cnt <= '0;
		end
		else
		begin
			case (state)
				ZS_IDLE:
					if (frame_strobe)
					begin
						strip_cnt <= '0;
						state <= ZS_STRIPS;
					end
				ZS_STRIPS:
					if (frame_strobe)
					begin
						strip_cnt <= strip_cnt + 1'b1;
						if (strip_cnt == STRIP_ADDR_W'(STRIPS_PER_FRAME - 1))
							state <= ZS_TRAILER;
					end
				ZS_TRAILER:
					if (frame_strobe)
						state <= ZS_EVT_TRAILER;
				ZS_EVT_TRAILER:
					state <= ZS_GAP;
				ZS_GAP:
					state <= ZS_IDLE;
				default:
					state <= ZS_IDLE;
			endcase
		end
	end

	// Decoder trailer and event trailer follow the samples down the same pipe,
	// so they always land behind the last hit
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			s1_valid <= 1'b0;
			s1_type <= WT_HEADER;
		end
		else if (all_clear)
			s1_valid <= 1'b0;
		else
		begin
			s1_valid <= 1'b0;
			if (frame_strobe && (state == ZS_STRIPS))
			begin
				s1_valid <= 1'b1;
				s1_type <= WT_HIT;
			end
			else if (frame_strobe && (state == ZS_TRAILER))
			begin
				s1_valid <= 1'b1;
				s1_type <= WT_DEC_TRAILER;
			end
			else if (state == ZS_EVT_TRAILER)
			begin
				s1_valid <= 1'b1;
				s1_type <= WT_EVT_TRAILER;
			end
		end
	end

	// Registered threshold read alongside the baseline subtraction
	always_ff @(posedge CLK)
	begin
		s1_thr <= thr_ram[strip_cnt];
		s1_strip <= strip_cnt;
		if (state == ZS_TRAILER)
			s1_data <= frame_data;
		else
			s1_data <= frame_data - {1'b0, enabled_mean};
	end

	// Unsigned compare, so a difference that wraps negative reads as large
	assign hit_pass = (s1_thr != THR_DISABLED) && (s1_data > {1'b0, s1_thr});

	always_comb
	begin
		if (header_go)
			next_word = {WT_HEADER, 1'b0, mean[SAMPLE_W-1], frame_data, ch_id};
		else
		begin
			case (s1_type)
				WT_DEC_TRAILER:
					next_word = {WT_DEC_TRAILER, 2'b00, module_id, s1_data[SAMPLE_W-1:0]};
				WT_EVT_TRAILER:
					next_word = {WT_EVT_TRAILER, mean[SAMPLE_W-2:0], word_count};
				default:
					next_word = {WT_HIT, s1_strip, s1_data[SAMPLE_W-1:0]};
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			fifo_wr <= 1'b0;
			event_done <= 1'b0;
			word_count <= WCNT_W'(WORD_COUNT_INIT);
		end
		else if (all_clear)
		begin
			fifo_wr <= 1'b0;
			event_done <= 1'b0;
			word_count <= WCNT_W'(WORD_COUNT_INIT);
		end
		else
		begin
			fifo_wr <= 1'b0;
			event_done <= 1'b0;
			if (header_go)
			begin
				fifo_wr <= 1'b1;
				word_count <= WCNT_W'(WORD_COUNT_INIT);
			end
			else if (s1_valid)
			begin
				case (s1_type)
					WT_HIT:
						if (hit_pass)
						begin
							fifo_wr <= 1'b1;
							word_count <= word_count + 1'b1;
						end
					WT_EVT_TRAILER:
					begin
						fifo_wr <= 1'b1;
						event_done <= 1'b1;
					end
					default:
						fifo_wr <= 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		fifo_wdata <= next_word;
	end

endmodule

// ==== logic/apv_pkg.sv ====
// Widths, frame geometry and word encodings shared by the APV readout channel; import where used
package apv_pkg;

	// Sample and frame word widths
	localparam int SAMPLE_W = 12;
	localparam int FRAME_W = 13;
	localparam int WORD_W = 21;

	// One APV frame carries 128 strips
	localparam int STRIP_ADDR_W = 7;
	localparam int STRIPS_PER_FRAME = 128;

	// Identifiers stamped into the header and decoder trailer
	localparam int CH_ID_W = 4;
	localparam int MODULE_ID_W = 5;

	// Output buffer geometry
	localparam int FIFO_DEPTH = 2048;
	localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_W = 12;

	// Complete events held in the output buffer
	localparam int EVCNT_W = 5;
	localparam int EVCNT_MAX = 31;

	// All ones switches a strip off
	localparam logic [SAMPLE_W-1:0] THR_DISABLED = '1;

	// Word count lives in the low byte of the event trailer
	localparam int WCNT_W = 8;
	localparam int WORD_COUNT_INIT = 2;

	// Opcode in the top two bits of every output word
	typedef enum logic [1:0] {
		WT_HEADER      = 2'b00,
		WT_HIT         = 2'b01,
		WT_DEC_TRAILER = 2'b10,
		WT_EVT_TRAILER = 2'b11
	} word_type_e;

	typedef enum logic [2:0] {
		ZS_IDLE,
		ZS_STRIPS,
		ZS_TRAILER,
		ZS_EVT_TRAILER,
		ZS_GAP
	} zs_state_e;

endpackage
